// ==== compile.f ====
+incdir+common
common/sdram_pkg.sv
sdram_ctrl/refresh_timer.sv
sdram_ctrl/access_sequencer.sv
sdram_ctrl/cmd_arbiter.sv
sdram_model/sdram_1mx16x4.sv
hdl/sdram_subsystem.sv
test/sdram_asserts.sv
test/tb_sdram.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_sdram
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_sdram.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module tb_sdram;
  import sdram_pkg::*;

  // Run length and size of the address pool
  localparam int N_REQ    = 600;
  localparam int NUM_ADDR = 8;
  // Per request worst case covers a bank cycle, one refresh, read return and margin
  localparam int REQ_BOUND      = `T_RC + `T_RFC + `CAS_LAT + 16;
  localparam int INIT_BOUND     = `INIT_WAIT + `T_RC + 2 * `T_RFC + 16;
  localparam int TIMEOUT_CYCLES = N_REQ * REQ_BOUND + INIT_BOUND + 8;

  logic        DRAM_CLK;
  logic        rst_n;
  logic        req_valid;
  sdram_req_t  req;
  logic        credit_return;
  logic        rsp_valid;
  sdram_rsp_t  rsp;

  // Address pool with two rows per bank so rows conflict
  logic [`SDRAM_BANK_W-1:0]  a_bank [NUM_ADDR];
  logic [`SDRAM_ROW_W-1:0]   a_row [NUM_ADDR];
  logic [`SDRAM_COL_W-1:0]   a_col [NUM_ADDR];
  // Reference contents of each pool address
  logic [15:0]               ref_mem [NUM_ADDR];
  // Expected reads in request order
  sdram_rsp_t                exp_q [$];
  // Request kinds in issue order with reads set
  bit                        kind_q [$];
  // Cycle in which each pending read response is due
  longint                    due_q [$];
  longint                    cyc = 0;
  int                        credits = `REQ_DEPTH;
  int                        sent = 0;
  int                        returned = 0;

  sdram_subsystem dut (
    .DRAM_CLK      (DRAM_CLK),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic build_addr_pool();
    int tmp;
    for (int i = 0; i < NUM_ADDR; i++)
    begin
      tmp       = i % `SDRAM_BANKS;
      a_bank[i] = tmp[`SDRAM_BANK_W-1:0];
      // Disjoint row ranges keep every pool entry unique
      tmp       = i * 7 + $urandom_range(0, 6);
      a_row[i]  = tmp[`SDRAM_ROW_W-1:0];
      tmp       = $urandom_range(0, `SDRAM_COLS - 1);
      a_col[i]  = tmp[`SDRAM_COL_W-1:0];
    end
  endtask

  // Sends one request and applies it to the reference in issue order
  task automatic send_request();
    sdram_req_t r;
    sdram_rsp_t e;
    int         idx;
    int         tmp;
    // First pass writes every pool address in full
    if (sent < NUM_ADDR)
    begin
      idx     = sent;
      r.write = 1'b1;
      r.mask  = 2'b00;
    end
    else
    begin
      idx     = $urandom_range(0, NUM_ADDR - 1);
      r.write = ($urandom_range(0, 1) == 1);
      tmp     = $urandom_range(0, 3);
      r.mask  = tmp[1:0];
    end
    tmp     = $urandom_range(0, 3);
    r.tag   = tmp[1:0];
    r.bank  = a_bank[idx];
    r.row   = a_row[idx];
    r.col   = a_col[idx];
    tmp     = $urandom;
    r.wdata = tmp[15:0];
    if (r.write)
    begin
      // Mask bit set keeps the old byte
      if (!r.mask[1])
        ref_mem[idx][15:8] = r.wdata[15:8];
      if (!r.mask[0])
        ref_mem[idx][7:0] = r.wdata[7:0];
    end
    else
    begin
      e.tag   = r.tag;
      e.rdata = ref_mem[idx];
      exp_q.push_back(e);
    end
    kind_q.push_back(!r.write);
    req       = r;
    req_valid = 1'b1;
    credits   = credits - 1;
    sent      = sent + 1;
  endtask

  initial
  begin
    DRAM_CLK = 1'b0;
    forever #2 DRAM_CLK = ~DRAM_CLK;
  end

  always @(posedge DRAM_CLK)
    cyc <= cyc + 1;

  // Outputs sampled mid-cycle well after the edge and the input drive
  always @(negedge DRAM_CLK)
  begin
    bit         is_rd;
    sdram_rsp_t e;
    if (rst_n)
    begin
      assert (!dut.u_cmd_arbiter.u_sdram_asserts.any_fail)
      else
        fail_run("A bound assertion on the SDRAM pin commands failed");
      if (sent == 0)
        assert (!credit_return && !rsp_valid)
        else
          fail_run($sformatf("[ERROR] %0t: output pulse before any request", $time));
      if (credit_return)
      begin
        assert (kind_q.size() > 0)
        else
          fail_run($sformatf("[ERROR] %0t: credit_return with nothing pending", $time));
        is_rd    = kind_q.pop_front();
        credits  = credits + 1;
        returned = returned + 1;
        if (is_rd)
          due_q.push_back(cyc + `CAS_LAT + 2);
      end
      if (rsp_valid)
      begin
        assert (due_q.size() > 0 && exp_q.size() > 0)
        else
          fail_run($sformatf("[ERROR] %0t: response with no read pending", $time));
        assert (due_q[0] == cyc)
        else
          fail_run($sformatf("[ERROR] %0t: response in cycle %0d, due in %0d",
                             $time, cyc, due_q[0]));
        void'(due_q.pop_front());
        e = exp_q.pop_front();
        assert (rsp.tag == e.tag && rsp.rdata == e.rdata)
        else
          fail_run($sformatf("[ERROR] %0t: got tag %0d data %h, expected tag %0d data %h",
                             $time, rsp.tag, rsp.rdata, e.tag, e.rdata));
      end
      // A due cycle left behind means a lost response
      if (due_q.size() > 0)
        assert (due_q[0] >= cyc)
        else
          fail_run($sformatf("[ERROR] %0t: response due in cycle %0d missing",
                             $time, due_q[0]));
    end
  end

  initial
  begin
    repeat (TIMEOUT_CYCLES) @(posedge DRAM_CLK);
    fail_run($sformatf("Watchdog timeout, run not finished after %0d cycles",
                       TIMEOUT_CYCLES));
  end

  initial
  begin
    void'($urandom(32'hdfd9));
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    build_addr_pool();
    repeat (4) @(posedge DRAM_CLK);
    #1;
    rst_n = 1'b1;
    // Client starts at once so early requests land during init
    while (sent < N_REQ)
    begin
      @(posedge DRAM_CLK);
      #1;
      req_valid = 1'b0;
      if (credits > 0 && $urandom_range(0, 3) != 0)
        send_request();
    end
    @(posedge DRAM_CLK);
    #1;
    req_valid = 1'b0;
    // Drain every credit and response
    while (returned != N_REQ || exp_q.size() != 0)
      @(posedge DRAM_CLK);
    repeat (`CAS_LAT + 4) @(posedge DRAM_CLK);
    if (credits == `REQ_DEPTH && returned == sent && due_q.size() == 0 &&
        !dut.u_cmd_arbiter.u_sdram_asserts.any_fail)
    begin
      $display("Testbench passed");
      $finish;
    end
    else
      fail_run("Run ended with credits or responses outstanding");
  end

endmodule

// ==== test/sdram_asserts.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_asserts (
  input logic                    DRAM_CLK,
  input logic                    rst_n,
  input logic                    init_done,
  input sdram_pkg::sdram_pins_t  pins
);
  import sdram_pkg::*;

  // Refresh may wait for an open access and the bank timers
  localparam int REF_SLACK = 16;

  logic [3:0]   cmd;
  logic         is_act;
  logic         is_access;
  logic         is_ref;
  // Cycles since the last ACT on any bank
  logic [7:0]   since_act;
  // Cycles since the last ACT per bank
  logic [7:0]   bank_gap [`SDRAM_BANKS];
  logic [7:0]   act_gap;
  // Cycles since the last REF, held at zero during init
  logic [15:0]  since_ref;
  // Sticky flags, one per property, visible to the testbench
  logic         rcd_bad = 1'b0;
  logic         rc_bad = 1'b0;
  logic         ref_bad = 1'b0;
  logic         any_fail;

  assign cmd       = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
  assign is_act    = (cmd == `CMD_ACT);
  assign is_access = (cmd == `CMD_READA) || (cmd == `CMD_WRITA);
  assign is_ref    = (cmd == `CMD_REF);
  assign act_gap   = bank_gap[pins.addr.rw.bank];
  assign any_fail  = rcd_bad | rc_bad | ref_bad;

  always_ff @(posedge DRAM_CLK)
  begin
    if (!rst_n)
    begin
      since_act <= 8'hff;
      since_ref <= '0;
      for (int b = 0; b < `SDRAM_BANKS; b++)
        bank_gap[b] <= 8'hff;
    end
    else
    begin
      if (is_act)
        since_act <= 8'd1;
      else if (since_act != 8'hff)
        since_act <= since_act + 8'd1;
      for (int b = 0; b < `SDRAM_BANKS; b++)
      begin
        if (is_act && int'(pins.addr.rw.bank) == b)
          bank_gap[b] <= 8'd1;
        else if (bank_gap[b] != 8'hff)
          bank_gap[b] <= bank_gap[b] + 8'd1;
      end
      // Interval counts from the end of init
      if (!init_done || is_ref)
        since_ref <= '0;
      else
        since_ref <= since_ref + 16'd1;
    end
  end

  // ACT to READA or WRITA
  rcd_spacing: assert property (@(posedge DRAM_CLK) disable iff (!rst_n)
    is_access |-> int'(since_act) >= `T_RCD)
  else
  begin
    $error("Access issued less than T_RCD after ACT");
    rcd_bad = 1'b1;
  end

  // Same bank ACT to ACT
  rc_spacing: assert property (@(posedge DRAM_CLK) disable iff (!rst_n)
    is_act |-> int'(act_gap) >= `T_RC)
  else
  begin
    $error("ACT to a bank within T_RC");
    rc_bad = 1'b1;
  end

  ref_period: assert property (@(posedge DRAM_CLK) disable iff (!rst_n)
    init_done |-> int'(since_ref) <= `REFRESH_INTERVAL + REF_SLACK)
  else
  begin
    $error("REF interval exceeded");
    ref_bad = 1'b1;
  end

endmodule

bind cmd_arbiter sdram_asserts u_sdram_asserts (
  .DRAM_CLK  (DRAM_CLK),
  .rst_n     (rst_n),
  .init_done (init_done),
  .pins      (pins)
);

// ==== hdl/sdram_subsystem.sv ====
`timescale 1ns/1ps

module sdram_subsystem (
  input  logic                   DRAM_CLK,
  input  logic                   rst_n,
  input  logic                   req_valid,
  input  sdram_pkg::sdram_req_t  req,
  output logic                   credit_return,
  output logic                   rsp_valid,
  output sdram_pkg::sdram_rsp_t  rsp
);
  import sdram_pkg::*;

  // Sequencer to arbiter
  logic         acc_req;
  logic         acc_gnt;
  access_cmd_t  acc_cmd;
  // Refresh timer to arbiter
  logic         ref_req;
  logic         ref_gnt;
  logic         init_done;
  // Device side
  sdram_pins_t  pins;
  // Shared data bus, written by arbiter and read back by the sequencer
  wire [15:0]   dram_dq;

  refresh_timer u_refresh_timer (
    .DRAM_CLK  (DRAM_CLK),
    .rst_n     (rst_n),
    .init_done (init_done),
    .ref_gnt   (ref_gnt),
    .ref_req   (ref_req)
  );

  access_sequencer u_access_sequencer (
    .DRAM_CLK      (DRAM_CLK),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .acc_req       (acc_req),
    .acc_cmd       (acc_cmd),
    .acc_gnt       (acc_gnt),
    .dq_in         (dram_dq),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  cmd_arbiter u_cmd_arbiter (
    .DRAM_CLK  (DRAM_CLK),
    .rst_n     (rst_n),
    .acc_req   (acc_req),
    .acc_cmd   (acc_cmd),
    .acc_gnt   (acc_gnt),
    .ref_req   (ref_req),
    .ref_gnt   (ref_gnt),
    .init_done (init_done),
    .pins      (pins),
    .dq        (dram_dq)
  );

  sdram_1mx16x4 u_sdram (
    .DRAM_CLK (DRAM_CLK),
    .rst_n    (rst_n),
    .pins     (pins),
    .dq       (dram_dq)
  );

endmodule

// ==== sdram_model/sdram_1mx16x4.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module sdram_1mx16x4 (
  input  logic                    DRAM_CLK,
  input  logic                    rst_n,
  input  sdram_pkg::sdram_pins_t  pins,
  inout  wire logic [15:0]        dq
);
  import sdram_pkg::*;

  typedef enum logic [1:0] {
    B_IDLE,
    B_ACTIVE,
    B_ACCESS_AP,
    B_PRECHARGE
  } bank_st_t;

  // Array, rows cut down for simulation
  logic [15:0]               mem [`SDRAM_BANKS][`SDRAM_ROWS][`SDRAM_COLS];
  bank_st_t                  bank_st [`SDRAM_BANKS];
  logic [`SDRAM_ROW_W-1:0]   row_lat [`SDRAM_BANKS];
  sdram_mode_t               mode_reg;
  // Read pipe, stage 0 loads at the command edge
  logic [2:0]                rd_vld;
  logic [15:0]               rd_q [3];
  logic [1:0]                rd_dqm [3];
  logic [3:0]                cmd;
  logic [`SDRAM_BANK_W-1:0]  cmd_bank;
  logic [`SDRAM_COL_W-1:0]   cmd_col;
  logic                      all_idle;
  logic                      act_cmd;
  logic                      rd_cmd;
  logic                      wr_cmd;
  logic [15:0]               cur_word;
  logic [1:0]                rd_sel;
  logic [1:0]                dq_oe;

  // Command decode, CKE is treated as always high
  assign cmd      = {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n};
  assign cmd_bank = pins.addr.rw.bank;
  assign cmd_col  = pins.addr.rw.a[`SDRAM_COL_W-1:0];
  assign act_cmd  = (cmd == `CMD_ACT) && (bank_st[cmd_bank] == B_IDLE);
  // Only auto-precharge accesses exist, A10 must be set
  assign rd_cmd   = (cmd == `CMD_READA) && pins.addr.rw.a[10] &&
                    (bank_st[cmd_bank] == B_ACTIVE);
  assign wr_cmd   = (cmd == `CMD_WRITA) && pins.addr.rw.a[10] &&
                    (bank_st[cmd_bank] == B_ACTIVE);
  // Word under the open row of the addressed bank
  assign cur_word = mem[cmd_bank][row_lat[cmd_bank]][cmd_col];

  always_comb
  begin
    all_idle = 1'b1;
    for (int b = 0; b < `SDRAM_BANKS; b++)
      if (bank_st[b] != B_IDLE)
        all_idle = 1'b0;
  end

  // CAS latency 3 takes the last stage, anything else behaves as 2
  assign rd_sel = (mode_reg.cas_lat == 3'd3) ? 2'd2 : 2'd1;
  // DQM travels with the read so it masks its own data
  assign dq_oe  = ~rd_dqm[rd_sel] & {2{rd_vld[rd_sel]}};
  assign dq     = {dq_oe[1] ? rd_q[rd_sel][15:8] : 8'hzz,
                   dq_oe[0] ? rd_q[rd_sel][7:0]  : 8'hzz};

  // Bank state machines and mode register
  always_ff @(posedge DRAM_CLK)
  begin
    if (!rst_n)
    begin
      for (int b = 0; b < `SDRAM_BANKS; b++)
        bank_st[b] <= B_IDLE;
      mode_reg <= '0;
      rd_vld   <= '0;
    end
    else
    begin
      for (int b = 0; b < `SDRAM_BANKS; b++)
      begin
        case (bank_st[b])
          B_IDLE:
          begin
            if (act_cmd && int'(cmd_bank) == b)
              bank_st[b] <= B_ACTIVE;
            // Refresh keeps every bank busy for a cycle
            else if (cmd == `CMD_REF && all_idle)
              bank_st[b] <= B_PRECHARGE;
          end
          B_ACTIVE:
          begin
            if ((rd_cmd || wr_cmd) && int'(cmd_bank) == b)
              bank_st[b] <= B_ACCESS_AP;
            // Precharge of this bank, or of all banks with A10
            else if (cmd == `CMD_PRE && (pins.addr.rw.a[10] || int'(cmd_bank) == b))
              bank_st[b] <= B_PRECHARGE;
          end
          // Auto-precharge starts right after the single beat
          B_ACCESS_AP: bank_st[b] <= B_PRECHARGE;
          default:     bank_st[b] <= B_IDLE;
        endcase
      end
      // Mode view of the address pins, accepted only with all banks idle
      if (cmd == `CMD_MRS && all_idle)
        mode_reg <= pins.addr.mode;
      rd_vld <= {rd_vld[1:0], rd_cmd};
    end
  end

  // Array, row latches and read data pipe
  always_ff @(posedge DRAM_CLK)
  begin
    if (act_cmd)
      row_lat[cmd_bank] <= pins.addr.rw.a[`SDRAM_ROW_W-1:0];
    // Masked bytes keep the old contents
    if (wr_cmd)
      mem[cmd_bank][row_lat[cmd_bank]][cmd_col] <=
        {pins.dqm[1] ? cur_word[15:8] : dq[15:8],
         pins.dqm[0] ? cur_word[7:0]  : dq[7:0]};
    rd_q[0]   <= cur_word;
    rd_dqm[0] <= pins.dqm;
    for (int i = 1; i < 3; i++)
    begin
      rd_q[i]   <= rd_q[i-1];
      rd_dqm[i] <= rd_dqm[i-1];
    end
  end

endmodule

// ==== sdram_ctrl/cmd_arbiter.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module cmd_arbiter (
  input  logic                    DRAM_CLK,
  input  logic                    rst_n,
  input  logic                    acc_req,
  input  sdram_pkg::access_cmd_t  acc_cmd,
  output logic                    acc_gnt,
  input  logic                    ref_req,
  output logic                    ref_gnt,
  output logic                    init_done,
  output sdram_pkg::sdram_pins_t  pins,
  inout  wire logic [15:0]        dq
);
  import sdram_pkg::*;

  // Power-up steps, each one waits for all_cnt to drain
  typedef enum logic [2:0] {
    I_WAIT,
    I_PRE,
    I_REF1,
    I_REF2,
    I_MRS,
    I_RUN
  } init_st_t;

  init_st_t     init_st;
  // Whole-device busy time after REF, MRS and power-up PRE
  logic [7:0]   all_cnt;
  // ACT to ACT spacing per bank
  logic [3:0]   bank_cnt [`SDRAM_BANKS];
  // ACT to access spacing
  logic [3:0]   rcd_cnt;
  // Read data still due on DQ, blocks write drive
  logic [3:0]   ta_cnt;
  logic         act_open;
  logic         banks_idle;
  logic         init_issue;
  logic         act_gnt;
  logic         rd_gnt;
  logic         wr_gnt;
  logic [3:0]   nxt_cmd;
  sdram_addr_u  nxt_addr;
  logic [1:0]   nxt_dqm;
  logic         dq_oe;
  logic [15:0]  dq_out;

  assign init_done  = (init_st == I_RUN);
  assign init_issue = !init_done && (all_cnt == 0);
  assign acc_gnt    = act_gnt | rd_gnt | wr_gnt;
  assign dq         = dq_oe ? dq_out : 'z;

  always_comb
  begin
    banks_idle = 1'b1;
    for (int b = 0; b < `SDRAM_BANKS; b++)
      if (bank_cnt[b] != 0)
        banks_idle = 1'b0;
  end

  // Grants, at most one per cycle
  always_comb
  begin
    act_gnt = 1'b0;
    rd_gnt  = 1'b0;
    wr_gnt  = 1'b0;
    ref_gnt = 1'b0;
    if (init_done)
    begin
      if (act_open)
      begin
        // Open row always gets its access before any refresh
        if (acc_req && rcd_cnt == 0)
        begin
          rd_gnt = (acc_cmd.kind == ACC_READ);
          wr_gnt = (acc_cmd.kind == ACC_WRITE) && (ta_cnt == 0);
        end
      end
      else if (ref_req)
        ref_gnt = banks_idle && (all_cnt == 0);
      else if (acc_req && acc_cmd.kind == ACC_ACT)
        act_gnt = (all_cnt == 0) && (bank_cnt[acc_cmd.bank] == 0);
    end
  end

  // Next pin word
  always_comb
  begin
    nxt_cmd  = `CMD_NOP;
    nxt_addr = '0;
    nxt_dqm  = 2'b00;
    if (init_issue)
    begin
      case (init_st)
        I_PRE:
        begin
          // A10 selects all banks
          nxt_cmd         = `CMD_PRE;
          nxt_addr.rw.a[10] = 1'b1;
        end
        I_REF1, I_REF2:
          nxt_cmd = `CMD_REF;
        I_MRS:
        begin
          // BL1, sequential, burst writes
          nxt_cmd                = `CMD_MRS;
          nxt_addr.mode.cas_lat  = 3'(`CAS_LAT);
          nxt_addr.mode.wrap     = 1'b0;
          nxt_addr.mode.burst_len = 3'b000;
        end
        default: ;
      endcase
    end
    else if (ref_gnt)
      nxt_cmd = `CMD_REF;
    else if (act_gnt)
    begin
      nxt_cmd                           = `CMD_ACT;
      nxt_addr.rw.bank                  = acc_cmd.bank;
      nxt_addr.rw.a[`SDRAM_ROW_W-1:0]   = acc_cmd.row;
    end
    else if (rd_gnt || wr_gnt)
    begin
      nxt_cmd                         = rd_gnt ? `CMD_READA : `CMD_WRITA;
      nxt_addr.rw.bank                = acc_cmd.bank;
      nxt_addr.rw.a[`SDRAM_COL_W-1:0] = acc_cmd.col;
      // Auto-precharge
      nxt_addr.rw.a[10]               = 1'b1;
      // Write mask rides on DQM, reads leave both bytes on
      nxt_dqm                         = wr_gnt ? acc_cmd.mask : 2'b00;
    end
  end

  always_ff @(posedge DRAM_CLK)
  begin
    if (!rst_n)
    begin
      init_st  <= I_WAIT;
      all_cnt  <= 8'(`INIT_WAIT);
      rcd_cnt  <= '0;
      ta_cnt   <= '0;
      act_open <= 1'b0;
      for (int b = 0; b < `SDRAM_BANKS; b++)
        bank_cnt[b] <= '0;
      {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n} <= `CMD_NOP;
      pins.addr <= '0;
      pins.dqm  <= 2'b00;
      pins.cke  <= 1'b1;
      dq_oe     <= 1'b0;
    end
    else
    begin
      // Timers drain by default, loads below take over
      if (all_cnt != 0)
        all_cnt <= all_cnt - 1'b1;
      if (rcd_cnt != 0)
        rcd_cnt <= rcd_cnt - 1'b1;
      if (ta_cnt != 0)
        ta_cnt <= ta_cnt - 1'b1;
      for (int b = 0; b < `SDRAM_BANKS; b++)
        if (bank_cnt[b] != 0)
          bank_cnt[b] <= bank_cnt[b] - 1'b1;

      if (init_issue)
      begin
        init_st <= init_st_t'(init_st + 3'd1);
        case (init_st)
          I_PRE:          all_cnt <= 8'(`T_RC - 1);
          I_REF1, I_REF2: all_cnt <= 8'(`T_RFC - 1);
          // Two cycles from MRS to first ACT
          I_MRS:          all_cnt <= 8'd1;
          default: ;
        endcase
      end
      if (ref_gnt)
        all_cnt <= 8'(`T_RFC - 1);
      if (act_gnt)
      begin
        bank_cnt[acc_cmd.bank] <= 4'(`T_RC - 1);
        rcd_cnt                <= 4'(`T_RCD - 1);
        act_open               <= 1'b1;
      end
      if (rd_gnt || wr_gnt)
        act_open <= 1'b0;
      if (rd_gnt)
        ta_cnt <= 4'(`CAS_LAT);

      // Pins follow the grant by one cycle
      {pins.cs_n, pins.ras_n, pins.cas_n, pins.we_n} <= nxt_cmd;
      pins.addr <= nxt_addr;
      pins.dqm  <= nxt_dqm;
      pins.cke  <= 1'b1;
      dq_oe     <= wr_gnt;
    end
  end

  // Write data shares the cycle of the WRITA pins
  always_ff @(posedge DRAM_CLK)
  begin
    dq_out <= acc_cmd.wdata;
  end

endmodule

// ==== sdram_ctrl/access_sequencer.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module access_sequencer (
  input  logic                    DRAM_CLK,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  sdram_pkg::sdram_req_t   req,
  output logic                    credit_return,
  output logic                    acc_req,
  output sdram_pkg::access_cmd_t  acc_cmd,
  input  logic                    acc_gnt,
  input  logic [15:0]             dq_in,
  output logic                    rsp_valid,
  output sdram_pkg::sdram_rsp_t   rsp
);
  import sdram_pkg::*;

  // Request queue, depth is a power of two so pointers wrap on their own
  sdram_req_t                     fifo [`REQ_DEPTH];
  logic [$clog2(`REQ_DEPTH)-1:0]  wr_ptr;
  logic [$clog2(`REQ_DEPTH)-1:0]  rd_ptr;
  logic [$clog2(`REQ_DEPTH):0]    count;
  sdram_req_t                     head;
  // Row of the head request is open
  logic                           act_done;
  logic                           pop;
  // Read tags in flight, one stage per cycle after the grant
  logic [`CAS_LAT:0]              rd_vld;
  logic [1:0]                     rd_tag [`CAS_LAT+1];

  assign head    = fifo[rd_ptr];
  assign acc_req = (count != 0);
  // Head leaves on its read or write grant, not on the ACT
  assign pop           = acc_gnt && act_done;
  assign credit_return = pop;

  always_comb
  begin
    if (!act_done)
      acc_cmd.kind = ACC_ACT;
    else if (head.write)
      acc_cmd.kind = ACC_WRITE;
    else
      acc_cmd.kind = ACC_READ;
    acc_cmd.bank  = head.bank;
    acc_cmd.row   = head.row;
    acc_cmd.col   = head.col;
    acc_cmd.wdata = head.wdata;
    acc_cmd.mask  = head.mask;
    acc_cmd.tag   = head.tag;
  end

  always_ff @(posedge DRAM_CLK)
  begin
    if (!rst_n)
    begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      act_done  <= 1'b0;
      rd_vld    <= '0;
      rsp_valid <= 1'b0;
    end
    else
    begin
      // Credits guarantee a free slot for every push
      if (req_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({req_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // ACT grant opens the row, access grant closes it again
      if (acc_gnt)
        act_done <= !act_done;
      rd_vld    <= {rd_vld[`CAS_LAT-1:0], pop && !head.write};
      // Last stage lines up with device data on DQ
      rsp_valid <= rd_vld[`CAS_LAT];
    end
  end

  // Queue storage and the read data path
  always_ff @(posedge DRAM_CLK)
  begin
    if (req_valid)
      fifo[wr_ptr] <= req;
    rd_tag[0] <= head.tag;
    for (int i = 1; i <= `CAS_LAT; i++)
      rd_tag[i] <= rd_tag[i-1];
    rsp.tag   <= rd_tag[`CAS_LAT];
    rsp.rdata <= dq_in;
  end

endmodule

// ==== sdram_ctrl/refresh_timer.sv ====
`timescale 1ns/1ps
`include "sdram_defines.svh"

module refresh_timer (
  input  logic DRAM_CLK,
  input  logic rst_n,
  input  logic init_done,
  input  logic ref_gnt,
  output logic ref_req
);

  logic [$clog2(`REFRESH_INTERVAL)-1:0] cnt;

  always_ff @(posedge DRAM_CLK)
  begin
    if (!rst_n)
    begin
      cnt     <= '0;
      ref_req <= 1'b0;
    end
    else if (!init_done || ref_gnt)
    begin
      // Interval restarts at the grant, so waiting for it never accumulates
      // Starting at one puts the rise exactly one interval after the grant
      cnt     <= 1'b1;
      ref_req <= 1'b0;
    end
    else if (!ref_req)
    begin
      if (int'(cnt) == `REFRESH_INTERVAL - 1)
        ref_req <= 1'b1;
      else
        cnt <= cnt + 1'b1;
    end
    // Pending request stays up until the arbiter takes it
  end

endmodule

// ==== common/sdram_pkg.sv ====
`include "sdram_defines.svh"

package sdram_pkg;

  // Single-word client request
  typedef struct packed {
    logic                      write;
    logic [1:0]                tag;
    logic [`SDRAM_BANK_W-1:0]  bank;
    logic [`SDRAM_ROW_W-1:0]   row;
    logic [`SDRAM_COL_W-1:0]   col;
    logic [15:0]               wdata;
    // High bit masks the upper byte
    logic [1:0]                mask;
  } sdram_req_t;

  // Read response, returned in request order
  typedef struct packed {
    logic [1:0]                tag;
    logic [15:0]               rdata;
  } sdram_rsp_t;

  // Bank and address pins seen as a row word
  // Column commands reuse it with the column in the low bits and A10 set
  typedef struct packed {
    logic [`SDRAM_BANK_W-1:0]  bank;
    logic [`SDRAM_ADDR_W-1:0]  a;
  } sdram_row_word_t;

  // Same pins seen as mode register fields during MRS
  typedef struct packed {
    logic [`SDRAM_BANK_W+1:0]  rsvd;
    logic                      wb_single;
    logic [1:0]                op_mode;
    logic [2:0]                cas_lat;
    logic                      wrap;
    logic [2:0]                burst_len;
  } sdram_mode_t;

  typedef union packed {
    sdram_row_word_t           rw;
    sdram_mode_t               mode;
  } sdram_addr_u;

  // Pin bundle from controller to device
  typedef struct packed {
    logic                      cs_n;
    logic                      ras_n;
    logic                      cas_n;
    logic                      we_n;
    sdram_addr_u               addr;
    logic [1:0]                dqm;
    logic                      cke;
  } sdram_pins_t;

  typedef enum logic [1:0] {
    ACC_ACT,
    ACC_READ,
    ACC_WRITE
  } acc_kind_t;

  // One step of a request, sequencer to arbiter
  typedef struct packed {
    acc_kind_t                 kind;
    logic [`SDRAM_BANK_W-1:0]  bank;
    logic [`SDRAM_ROW_W-1:0]   row;
    logic [`SDRAM_COL_W-1:0]   col;
    logic [15:0]               wdata;
    logic [1:0]                mask;
    logic [1:0]                tag;
  } access_cmd_t;

endpackage

// ==== common/sdram_defines.svh ====
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// Device geometry, reduced row count for simulation
`define SDRAM_BANKS       4
`define SDRAM_ROWS        64
`define SDRAM_COLS        256
`define SDRAM_BANK_W      $clog2(`SDRAM_BANKS)
`define SDRAM_ROW_W       $clog2(`SDRAM_ROWS)
`define SDRAM_COL_W       $clog2(`SDRAM_COLS)
// Address pins A11..A0
`define SDRAM_ADDR_W      12

// Request queue depth, also the client's starting credit count
`define REQ_DEPTH         4

// Read latency written into the mode register
`define CAS_LAT           2

// Timing in controller clock cycles
`define T_RCD             2
`define T_RC              6
`define T_RFC             6
`define REFRESH_INTERVAL  200
`define INIT_WAIT         20

// Command pins {cs_n, ras_n, cas_n, we_n}
// READA and WRITA also need A10 high
`define CMD_NOP           4'b0111
`define CMD_ACT           4'b0011
`define CMD_READA         4'b0101
`define CMD_WRITA         4'b0100
`define CMD_PRE           4'b0010
`define CMD_REF           4'b0001
`define CMD_MRS           4'b0000

`endif
